//--- Bender.yml
package:
  name: fpu_unit

sources:
  - fpu_pkg.sv
  - fpu_decode.sv
  - fp_floor.sv
  - fp_to_int.sv
  - int_to_fp.sv
  - fpu_result.sv
  - fpu_unit.sv
  - target: simulation
    files:
      - tb_fpu.sv

//--- fp_floor.sv
`timescale 1ns/1ns

module fp_floor (
	input fpu_pkg::float_t x,
	output fpu_pkg::float_t y
);

	logic s;
	fpu_pkg::exp_t e;
	fpu_pkg::frac_t f;
	logic is_nan;
	logic [4:0] sh;          // position of the binary point, 0 to 22
	logic [45:0] aligned;    // integer part in [45:23], fraction below
	logic cut;
	logic [23:0] int_part;   // extra msb for the carry
	logic [46:0] back;
	fpu_pkg::exp_t e_out;

	assign s = x[31];
	assign e = x[30:23];
	assign f = x[22:0];

	assign is_nan = (e == fpu_pkg::EXP_SPECIAL) && (f != '0);

	// only meaningful for 127 <= e < 150
	assign sh = 5'(e - fpu_pkg::EXP_BIAS);
	assign aligned = {23'd1, f} << sh;

	// negative values with dropped fraction bits move one step down
	assign cut = s & (|aligned[22:0]);
	assign int_part = {1'b0, aligned[45:23]} + {23'd0, cut};

	// shift back so the hidden bit sits at bit 23 again
	assign back = {int_part, 23'd0} >> sh;
	assign e_out = e + {7'd0, back[24]}; // magnitude hit the next power of two

	always_comb begin
		if (is_nan) begin
			y = {s, e, 1'b1, f[21:0]}; // force quiet
		end else if (e >= fpu_pkg::EXP_INT_MIN) begin
			y = x; // already integral, also inf
		end else if (e < fpu_pkg::EXP_BIAS) begin
			if (s && (x[30:0] != '0)) begin
				y = {1'b1, fpu_pkg::EXP_BIAS, 23'd0}; // -1.0
			end else begin
				y = {s, 31'd0};
			end
		end else begin
			y = {s, e_out, back[22:0]};
		end
	end

endmodule

//--- fp_to_int.sv
`timescale 1ns/1ns

module fp_to_int (
	input fpu_pkg::float_t x,
	output fpu_pkg::word_t y,
	output logic ovf,
	output logic nan
);

	logic s;
	fpu_pkg::exp_t e;
	fpu_pkg::frac_t f;
	logic [23:0] mant;
	fpu_pkg::exp_t sh;
	logic [55:0] shifted;    // integer in [55:24], half bit at 23
	logic [32:0] rounded;
	logic tiny;
	logic too_big;
	logic min_int;
	logic range_ovf;

	assign s = x[31];
	assign e = x[30:23];
	assign f = x[22:0];

	assign mant = {(e != '0), f}; // hidden bit only for normals

	// e = 126 leaves the hidden bit on the half position
	assign sh = e - (fpu_pkg::EXP_BIAS - 8'd1);
	assign shifted = {32'd0, mant} << sh;

	// half away from zero, applied to the magnitude
	assign rounded = {1'b0, shifted[55:24]} + {32'd0, shifted[23]};

	assign nan = (e == fpu_pkg::EXP_SPECIAL) && (f != '0);
	assign tiny = e < (fpu_pkg::EXP_BIAS - 8'd1);
	assign too_big = e > fpu_pkg::EXP_FTOI_MAX;
	assign min_int = s && (rounded == {2'b01, 31'd0}); // exactly -2^31 still fits
	assign range_ovf = rounded[32] | rounded[31];

	always_comb begin
		y = '0;
		ovf = 1'b0;
		if (nan) begin
			y = '0;
		end else if (too_big) begin
			ovf = 1'b1; // includes infinity
		end else if (tiny) begin
			y = '0;
		end else if (min_int) begin
			y = {1'b1, 31'd0};
		end else if (range_ovf) begin
			ovf = 1'b1;
		end else if (s) begin
			y = -rounded[31:0];
		end else begin
			y = rounded[31:0];
		end
	end

endmodule

//--- fpu_decode.sv
`timescale 1ns/1ns

module fpu_decode (
	input fpu_pkg::fpu_instr_t instr,
	output fpu_pkg::op_code_t op,
	output logic invalid
);

	logic is_cop1;
	logic is_ftoi;
	logic is_itof;

	assign is_cop1 = (instr.op1 == fpu_pkg::OPC_COP1);

	// conversions only with the zero function field
	assign is_ftoi = (instr.fmt == fpu_pkg::FMT_S_TO_W) && (instr.op2 == fpu_pkg::FN_CVT);
	assign is_itof = (instr.fmt == fpu_pkg::FMT_W_TO_S) && (instr.op2 == fpu_pkg::FN_CVT);

	always_comb begin
		op = fpu_pkg::OP_ABS;
		invalid = 1'b0;
		if (!is_cop1) begin
			invalid = 1'b1; // not a float instruction at all
		end else if (instr.fmt == fpu_pkg::FMT_S) begin
			case (instr.op2)
				fpu_pkg::FN_ABS: begin
					op = fpu_pkg::OP_ABS;
				end
				fpu_pkg::FN_NEG: begin
					op = fpu_pkg::OP_NEG;
				end
				fpu_pkg::FN_FLOOR: begin
					op = fpu_pkg::OP_FLOOR;
				end
				default: begin
					// add, sub, mul and div end up here as well
					invalid = 1'b1;
				end
			endcase
		end else if (is_ftoi) begin
			op = fpu_pkg::OP_FTOI;
		end else if (is_itof) begin
			op = fpu_pkg::OP_ITOF;
		end else begin
			invalid = 1'b1;
		end
	end

endmodule

//--- fpu_pkg.sv
package fpu_pkg;

	// words on the datapath
	typedef logic [31:0] float_t;        // ieee single
	typedef logic signed [31:0] word_t;  // two's complement integer
	typedef logic [7:0] exp_t;           // biased exponent
	typedef logic [22:0] frac_t;         // stored fraction, hidden bit not included

	localparam exp_t EXP_BIAS = 8'd127;
	localparam exp_t EXP_SPECIAL = 8'd255;  // inf and nan
	localparam exp_t EXP_INT_MIN = 8'd150;  // 127 + 23, no fraction bits left
	localparam exp_t EXP_FTOI_MAX = 8'd158; // 127 + 31

	// instruction fields seen by the unit
	typedef struct packed {
		logic [5:0] op1; // primary opcode
		logic [4:0] fmt; // format
		logic [5:0] op2; // function
	} fpu_instr_t;

	localparam logic [5:0] OPC_COP1 = 6'b010001;

	localparam logic [4:0] FMT_S = 5'b10000;
	localparam logic [4:0] FMT_W_TO_S = 5'b00100; // cvt.s.w
	localparam logic [4:0] FMT_S_TO_W = 5'b00000; // cvt.w.s

	localparam logic [5:0] FN_ABS = 6'd5;
	localparam logic [5:0] FN_NEG = 6'd7;
	localparam logic [5:0] FN_FLOOR = 6'd15;
	localparam logic [5:0] FN_CVT = 6'd0; // function field of both conversions

	// decoded operation
	typedef logic [2:0] op_code_t;

	localparam op_code_t OP_ABS = 3'd0;
	localparam op_code_t OP_NEG = 3'd1;
	localparam op_code_t OP_FLOOR = 3'd2;
	localparam op_code_t OP_FTOI = 3'd3;
	localparam op_code_t OP_ITOF = 3'd4;

	// reads as the 4-bit exception code, 1000 for an unknown instruction
	typedef struct packed {
		logic invalid;
		logic div0;    // no divider here, stays 0
		logic nan;
		logic ovf;
	} fpu_exc_t;

endpackage

//--- fpu_result.sv
`timescale 1ns/1ns

module fpu_result (
	input logic clk,
	input logic rst_n,
	input fpu_pkg::op_code_t op,
	input logic invalid,
	input fpu_pkg::float_t x1,
	input fpu_pkg::float_t floor_y,
	input fpu_pkg::word_t ftoi_y,
	input logic ftoi_ovf,
	input logic ftoi_nan,
	input fpu_pkg::float_t itof_y,
	output fpu_pkg::float_t y,
	output fpu_pkg::fpu_exc_t exc
);

	fpu_pkg::float_t abs_y;
	fpu_pkg::float_t neg_y;
	fpu_pkg::float_t y_d;
	fpu_pkg::fpu_exc_t exc_d;

	// sign bit only, nan payload untouched
	assign abs_y = {1'b0, x1[30:0]};
	assign neg_y = {~x1[31], x1[30:0]};

	always_comb begin
		y_d = '0;
		exc_d = '0;
		if (invalid) begin
			exc_d.invalid = 1'b1; // code 1000
		end else begin
			case (op)
				fpu_pkg::OP_ABS: y_d = abs_y;
				fpu_pkg::OP_NEG: y_d = neg_y;
				fpu_pkg::OP_FLOOR: y_d = floor_y;
				fpu_pkg::OP_FTOI: begin
					y_d = fpu_pkg::float_t'(ftoi_y);
					exc_d.nan = ftoi_nan;
					exc_d.ovf = ftoi_ovf;
				end
				fpu_pkg::OP_ITOF: y_d = itof_y;
				default: exc_d.invalid = 1'b1;
			endcase
		end
	end

	// one cycle from instruction to result
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			y <= '0;
			exc <= '0;
		end else begin
			y <= y_d;
			exc <= exc_d;
		end
	end

endmodule

//--- fpu_unit.sv
`timescale 1ns/1ns

module fpu_unit (
	input logic clk,
	input logic rst_n,
	input fpu_pkg::fpu_instr_t instr,
	input fpu_pkg::float_t x1,   // fs
	input fpu_pkg::word_t x2,    // ft, integer source of itof
	output fpu_pkg::float_t y,
	output fpu_pkg::fpu_exc_t exc
);

	fpu_pkg::op_code_t op;
	logic invalid;
	fpu_pkg::float_t floor_y;
	fpu_pkg::word_t ftoi_y;
	logic ftoi_ovf;
	logic ftoi_nan;
	fpu_pkg::float_t itof_y;

	fpu_decode fpu_decode_i (
		.instr   (instr),
		.op      (op),
		.invalid (invalid)
	);

	fp_floor fp_floor_i (
		.x (x1),
		.y (floor_y)
	);

	fp_to_int fp_to_int_i (
		.x   (x1),
		.y   (ftoi_y),
		.ovf (ftoi_ovf),
		.nan (ftoi_nan)
	);

	int_to_fp int_to_fp_i (
		.x (x2),
		.y (itof_y)
	);

	// abs and neg are formed inside the result stage
	fpu_result fpu_result_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.op       (op),
		.invalid  (invalid),
		.x1       (x1),
		.floor_y  (floor_y),
		.ftoi_y   (ftoi_y),
		.ftoi_ovf (ftoi_ovf),
		.ftoi_nan (ftoi_nan),
		.itof_y   (itof_y),
		.y        (y),
		.exc      (exc)
	);

endmodule

//--- int_to_fp.sv
`timescale 1ns/1ns

module int_to_fp (
	input fpu_pkg::word_t x,
	output fpu_pkg::float_t y
);

	logic s;
	logic [31:0] mag;        // unsigned, so -2^31 is fine
	logic [4:0] lead;
	logic [31:0] norm;       // leading one moved to bit 31
	logic guard;
	logic sticky;
	logic round_up;
	logic [24:0] rounded;    // carry, hidden bit, 23 fraction bits
	fpu_pkg::exp_t e;

	assign s = x[31];
	assign mag = s ? (~x + 32'd1) : x;

	// highest set bit wins
	always_comb begin
		lead = 5'd0;
		for (int i = 0; i < 32; i++) begin
			if (mag[i]) begin
				lead = i[4:0];
			end
		end
	end

	assign norm = mag << (5'd31 - lead);

	assign guard = norm[7];
	assign sticky = |norm[6:0];
	assign round_up = guard & (norm[8] | sticky); // ties go to even

	assign rounded = {1'b0, norm[31:8]} + {24'd0, round_up};

	// on carry the fraction bits are all zero anyway
	assign e = {3'd0, lead} + fpu_pkg::EXP_BIAS + {7'd0, rounded[24]};

	always_comb begin
		if (x == '0) begin
			y = '0; // +0.0
		end else begin
			y = {s, e, rounded[22:0]};
		end
	end

endmodule

//--- tb_fpu.sv
`timescale 1ns/1ns

module tb_fpu;

	localparam int NUM_TESTS = 29;
	localparam int CLK_PERIOD = 100;

	// instruction fields written out as in the isa
	localparam logic [5:0] COP1 = 6'b010001;
	localparam logic [4:0] FMT_SINGLE = 5'b10000;
	localparam logic [4:0] FMT_FROM_W = 5'b00100; // cvt.s.w
	localparam logic [4:0] FMT_TO_W = 5'b00000;   // cvt.w.s

	logic clk;
	logic rst_n;
	fpu_pkg::fpu_instr_t instr;
	fpu_pkg::float_t x1;
	fpu_pkg::word_t x2;
	fpu_pkg::float_t y;
	fpu_pkg::fpu_exc_t exc;

	// stimulus and expected values for each test
	string tbl_name [NUM_TESTS];
	fpu_pkg::fpu_instr_t tbl_instr [NUM_TESTS];
	logic [31:0] tbl_x1 [NUM_TESTS];
	logic [31:0] tbl_x2 [NUM_TESTS];
	logic [31:0] tbl_y [NUM_TESTS];
	logic [3:0] tbl_exc [NUM_TESTS];
	int n_entries;
	int n_pass;
	int n_fail;
	int unsigned seed_val;

	fpu_unit fpu_unit_i (
		.clk   (clk),
		.rst_n (rst_n),
		.instr (instr),
		.x1    (x1),
		.x2    (x2),
		.y     (y),
		.exc   (exc)
	);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic fpu_pkg::fpu_instr_t encode_instr(input logic [5:0] op1,
			input logic [4:0] fmt, input logic [5:0] op2);
		return {op1, fmt, op2};
	endfunction

	task automatic add_entry(input string name, input fpu_pkg::fpu_instr_t ins,
			input logic [31:0] a, input logic [31:0] b,
			input logic [31:0] exp_y, input logic [3:0] exp_exc);
		if (n_entries < NUM_TESTS) begin
			tbl_name[n_entries] = name;
			tbl_instr[n_entries] = ins;
			tbl_x1[n_entries] = a;
			tbl_x2[n_entries] = b;
			tbl_y[n_entries] = exp_y;
			tbl_exc[n_entries] = exp_exc;
		end
		n_entries++;
	endtask

	task automatic build_table();
		logic [31:0] r;
		fpu_pkg::fpu_instr_t i_abs;
		fpu_pkg::fpu_instr_t i_neg;
		fpu_pkg::fpu_instr_t i_floor;
		fpu_pkg::fpu_instr_t i_ftoi;
		fpu_pkg::fpu_instr_t i_itof;
		i_abs = encode_instr(COP1, FMT_SINGLE, 6'd5);
		i_neg = encode_instr(COP1, FMT_SINGLE, 6'd7);
		i_floor = encode_instr(COP1, FMT_SINGLE, 6'd15);
		i_ftoi = encode_instr(COP1, FMT_TO_W, 6'd0);
		i_itof = encode_instr(COP1, FMT_FROM_W, 6'd0);
		// abs clears bit 31 and neg flips it
		for (int k = 0; k < 4; k++) begin
			r = $urandom();
			add_entry($sformatf("fabs_rand%0d", k), i_abs, r, 32'h0,
				{1'b0, r[30:0]}, 4'b0000);
			r = $urandom();
			add_entry($sformatf("fneg_rand%0d", k), i_neg, r, 32'h0,
				{~r[31], r[30:0]}, 4'b0000);
		end
		add_entry("floor_2p5", i_floor, 32'h40200000, 32'h0, 32'h40000000, 4'b0000);
		add_entry("floor_m2p5", i_floor, 32'hC0200000, 32'h0, 32'hC0400000, 4'b0000);
		add_entry("floor_m0p3", i_floor, 32'hBE99999A, 32'h0, 32'hBF800000, 4'b0000);
		add_entry("floor_0p7", i_floor, 32'h3F333333, 32'h0, 32'h00000000, 4'b0000);
		add_entry("floor_1e9", i_floor, 32'h4E6E6B28, 32'h0, 32'h4E6E6B28, 4'b0000);
		add_entry("floor_snan", i_floor, 32'h7F800001, 32'h0, 32'h7FC00001, 4'b0000);
		add_entry("add_invalid", encode_instr(COP1, FMT_SINGLE, 6'd0), 32'h40200000, 32'h0,
			32'h0, 4'b1000);
		add_entry("ftoi_2p5", i_ftoi, 32'h40200000, 32'h0, 32'h00000003, 4'b0000);
		add_entry("ftoi_m2p5", i_ftoi, 32'hC0200000, 32'h0, 32'hFFFFFFFD, 4'b0000);
		add_entry("ftoi_0p4", i_ftoi, 32'h3ECCCCCD, 32'h0, 32'h00000000, 4'b0000);
		add_entry("ftoi_min_int", i_ftoi, 32'hCF000000, 32'h0, 32'h80000000, 4'b0000);
		add_entry("ftoi_3e9", i_ftoi, 32'h4F32D05E, 32'h0, 32'h00000000, 4'b0001);
		add_entry("ftoi_nan", i_ftoi, 32'h7FC00000, 32'h0, 32'h00000000, 4'b0010);
		add_entry("sub_invalid", encode_instr(COP1, FMT_SINGLE, 6'd1), 32'hC0200000, 32'h0,
			32'h0, 4'b1000);
		add_entry("itof_zero", i_itof, 32'h0, 32'h00000000, 32'h00000000, 4'b0000);
		add_entry("itof_m1", i_itof, 32'h0, 32'hFFFFFFFF, 32'hBF800000, 4'b0000);
		add_entry("itof_tie_even", i_itof, 32'h0, 32'h01000001, 32'h4B800000, 4'b0000);
		add_entry("itof_max", i_itof, 32'h0, 32'h7FFFFFFF, 32'h4F000000, 4'b0000);
		add_entry("mul_invalid", encode_instr(COP1, FMT_SINGLE, 6'd2), 32'h3F800000, 32'h0,
			32'h0, 4'b1000);
		add_entry("div_invalid", encode_instr(COP1, FMT_SINGLE, 6'd3), 32'h3F800000, 32'h0,
			32'h0, 4'b1000);
		add_entry("unknown_op1", encode_instr(6'b000000, FMT_SINGLE, 6'd5), 32'hBF800000, 32'h0,
			32'h0, 4'b1000); // fabs function under a wrong opcode
	endtask

	task automatic apply_entry(input int i);
		instr = tbl_instr[i];
		x1 = tbl_x1[i];
		x2 = tbl_x2[i];
	endtask

	task automatic check_entry(input int i);
		if (y !== tbl_y[i] || exc !== tbl_exc[i]) begin
			$display("MISMATCH %s: expected y=%h exc=%b, actual y=%h exc=%b",
				tbl_name[i], tbl_y[i], tbl_exc[i], y, exc);
			n_fail++;
		end else begin
			$display("ok %s: y=%h exc=%b", tbl_name[i], y, exc);
			n_pass++;
		end
	endtask

	// table length plus reset and margin
	initial begin
		#((NUM_TESTS + 20) * CLK_PERIOD);
		$display("watchdog expired before all tests finished");
		$display("Simulation failed");
		$finish;
	end

	initial begin
		seed_val = $urandom(5144);
		n_entries = 0;
		n_pass = 0;
		n_fail = 0;
		rst_n = 1'b0;
		instr = '0;
		x1 = '0;
		x2 = '0;
		build_table();
		if (n_entries != NUM_TESTS) begin
			$display("table holds %0d entries instead of %0d", n_entries, NUM_TESTS);
			n_fail++;
		end
		repeat (5) @(posedge clk);
		@(negedge clk);
		if (y !== 32'h0 || exc !== 4'b0000) begin // still in reset here
			$display("MISMATCH reset: expected y=%h exc=%b, actual y=%h exc=%b",
				32'h0, 4'b0000, y, exc);
			n_fail++;
		end else begin
			$display("ok reset: y=%h exc=%b", y, exc);
			n_pass++;
		end
		rst_n = 1'b1;
		apply_entry(0);
		// each check sees the entry applied one cycle before
		for (int i = 1; i < NUM_TESTS; i++) begin
			@(negedge clk);
			check_entry(i - 1);
			apply_entry(i);
		end
		@(negedge clk);
		check_entry(NUM_TESTS - 1);
		$display("tests: %0d passed, %0d failed", n_pass, n_fail);
		if (n_fail == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

//--- verilog.f
fpu_pkg.sv
fpu_decode.sv
fp_floor.sv
fp_to_int.sv
int_to_fp.sv
fpu_result.sv
fpu_unit.sv
tb_fpu.sv
